//--- tb.f
common/rvc_pkg.sv
common/align_if.sv
expander/rvc_expander.sv
fetch/align_ctrl.sv
fetch/fetch_pc_counter.sv
fetch/instr_assembler.sv
hw/rvc_fetch_top.sv
tb/rvc_fetch_assertions.sv
tb/rvc_fetch_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch aligner testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module rvc_fetch_tb -f tb.f --Mdir obj_dir -o rvc_fetch_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/rvc_fetch_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q -F -x '*** PASSED ***' sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb/rvc_fetch_tb.sv
`timescale 1ns/10ps

module rvc_fetch_tb;
	import rvc_pkg::*;

	localparam int MEM_WORDS  = 128;
	localparam int MEM_HALVES = 2 * MEM_WORDS;
	localparam int MAX_CYCLES = 20000;

	logic clk;
	logic rst_n;
	logic stall_i;
	logic jump_i;
	addr_t jump_target_i;
	instr_t fetch_data_i;
	addr_t fetch_addr_o;
	instr_t instr_o;
	addr_t instr_pc_o;
	logic instr_valid_o;
	logic is_compress_o;

	// lfsr state
	logic [15:0] lfsr;
	// byte-reversed cache image
	instr_t mem [0:MEM_WORDS-1];
	half_t halves [0:MEM_HALVES-1];
	// expected stream, one entry per instruction
	instr_t exp_instr [0:MEM_HALVES-1];
	addr_t exp_pc [0:MEM_HALVES-1];
	logic exp_comp [0:MEM_HALVES-1];
	// record index per halfword, -1 if no instruction starts there
	int start_rec [0:MEM_HALVES-1];
	int num_rec;
	int hcount;

	rvc_fetch_top rvc_fetch_top_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall_i       (stall_i),
		.jump_i        (jump_i),
		.jump_target_i (jump_target_i),
		.fetch_data_i  (fetch_data_i),
		.fetch_addr_o  (fetch_addr_o),
		.instr_o       (instr_o),
		.instr_pc_o    (instr_pc_o),
		.instr_valid_o (instr_valid_o),
		.is_compress_o (is_compress_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_instr(input string name, input instr_t exp_v, input instr_t act_v);
		if (act_v !== exp_v) begin
			report_failure($sformatf("error %s: expected %08h, actual %08h", name, exp_v, act_v));
		end
	endtask

	task automatic check_pc(input string name, input addr_t exp_v, input addr_t act_v);
		if (act_v !== exp_v) begin
			report_failure($sformatf("error %s: expected %08h, actual %08h", name, exp_v, act_v));
		end
	endtask

	task automatic check_flag(input string name, input logic exp_v, input logic act_v);
		if (act_v !== exp_v) begin
			report_failure($sformatf("error %s: expected %0b, actual %0b", name, exp_v, act_v));
		end
	endtask

	// new record starting at the current halfword
	task automatic push_record(input instr_t value, input logic comp);
		exp_instr[num_rec] = value;
		exp_pc[num_rec] = hcount * 2;
		exp_comp[num_rec] = comp;
		start_rec[hcount] = num_rec;
		num_rec++;
	endtask

	task automatic add_word32();
		instr_t w;
		w = take_bits(30);
		// low bits 11 mark a 32-bit instruction
		w = {w[29:0], 2'b11};
		push_record(w, 1'b0);
		halves[hcount] = w[15:0];
		halves[hcount + 1] = w[31:16];
		hcount += 2;
	endtask

	// pick fields, then lay out both the parcel and its rv32i form
	task automatic build_compressed(input c_op_e op, output half_t h, output instr_t e);
		logic [31:0] r1;
		logic [31:0] r2;
		logic [4:0] rd;
		logic [4:0] rs2;
		logic [2:0] rdp;
		logic [2:0] rsp;
		logic [5:0] imm;
		logic [11:0] off;
		logic [11:0] j;
		logic [8:0] b;
		r1 = take_bits(32);
		r2 = take_bits(16);
		rd = r1[4:0];
		rs2 = r1[9:5];
		rdp = r1[12:10];
		rsp = r1[15:13];
		imm = r1[21:16];
		// word offset of lw/sw, bits 6:2
		off = {5'b0, r1[26:22], 2'b00};
		j = {r2[13:3], 1'b0};
		b = {r1[31:27], r2[2:0], 1'b0};
		case (op)
			C_LW: begin
				h = {3'b010, off[5:3], rsp, off[2], off[6], rdp, 2'b00};
				e = {off, 2'b01, rsp, 3'b010, 2'b01, rdp, 7'b0000011};
			end
			C_SW: begin
				h = {3'b110, off[5:3], rsp, off[2], off[6], rdp, 2'b00};
				e = {off[11:5], 2'b01, rdp, 2'b01, rsp, 3'b010, off[4:0], 7'b0100011};
			end
			C_ADDI: begin
				h = {3'b000, imm[5], rd, imm[4:0], 2'b01};
				e = {{6{imm[5]}}, imm, rd, 3'b000, rd, 7'b0010011};
			end
			C_LI: begin
				h = {3'b010, imm[5], rd, imm[4:0], 2'b01};
				e = {{6{imm[5]}}, imm, 5'd0, 3'b000, rd, 7'b0010011};
			end
			C_LUI: begin
				// x2 would be addi16sp, zero imm reserved
				if (rd == 5'd2) rd = 5'd3;
				if (imm == 6'd0) imm = 6'd1;
				h = {3'b011, imm[5], rd, imm[4:0], 2'b01};
				e = {{14{imm[5]}}, imm, rd, 7'b0110111};
			end
			C_SLLI: begin
				h = {3'b000, 1'b0, rd, imm[4:0], 2'b10};
				e = {7'b0, imm[4:0], rd, 3'b001, rd, 7'b0010011};
			end
			C_MV: begin
				if (rs2 == 5'd0) rs2 = 5'd1;
				h = {3'b100, 1'b0, rd, rs2, 2'b10};
				e = {7'b0, rs2, 5'd0, 3'b000, rd, 7'b0110011};
			end
			C_ADD: begin
				if (rs2 == 5'd0) rs2 = 5'd1;
				h = {3'b100, 1'b1, rd, rs2, 2'b10};
				e = {7'b0, rs2, rd, 3'b000, rd, 7'b0110011};
			end
			C_JR: begin
				if (rd == 5'd0) rd = 5'd1;
				h = {3'b100, 1'b0, rd, 5'd0, 2'b10};
				e = {12'd0, rd, 3'b000, 5'd0, 7'b1100111};
			end
			C_J: begin
				h = {3'b101, j[11], j[4], j[9:8], j[10], j[6], j[7], j[3:1], j[5], 2'b01};
				e = {j[11], j[10:1], j[11], {8{j[11]}}, 5'd0, 7'b1101111};
			end
			C_BEQZ, C_BNEZ: begin
				h = {(op == C_BEQZ) ? 3'b110 : 3'b111, b[8], b[4:3], rsp, b[7:6], b[2:1],
				     b[5], 2'b01};
				e = {{3{b[8]}}, b[8:5], 5'd0, 2'b01, rsp, (op == C_BEQZ) ? 3'b000 : 3'b001,
				     b[4:1], b[8], 7'b1100011};
			end
			default: begin
				// quadrant 0 forms outside the supported set
				case (r2[15:14])
					2'd0: h = {3'b000, j[11:1], 2'b00};
					2'd1: h = {3'b001, j[11:1], 2'b00};
					2'd2: h = {3'b011, j[11:1], 2'b00};
					default: h = {3'b101, j[11:1], 2'b00};
				endcase
				e = ILLEGAL_INSTR;
			end
		endcase
	endtask

	task automatic add_compressed(input c_op_e op);
		half_t h;
		instr_t e;
		build_compressed(op, h, e);
		push_record(e, 1'b1);
		halves[hcount] = h;
		hcount++;
	endtask

	task automatic build_stream();
		logic [31:0] r;
		logic [31:0] sel;
		instr_t w;
		num_rec = 0;
		hcount = 0;
		for (int i = 0; i < MEM_HALVES; i++) start_rec[i] = -1;
		// aligned 32-bit run
		for (int i = 0; i < 8; i++) add_word32();
		// every form once, each followed by a word that straddles or aligns
		for (int k = 0; k < 13; k++) begin
			sel = k;
			add_compressed(c_op_e'(sel[3:0]));
			add_word32();
		end
		// random mix until the array is full
		while (hcount < MEM_HALVES) begin
			r = take_bits(1);
			if (r == 32'd1 && hcount + 2 <= MEM_HALVES) begin
				add_word32();
			end else begin
				r = take_bits(4);
				add_compressed(r[3:0] < 4'd12 ? c_op_e'(r[3:0]) : C_ILLEGAL);
			end
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			w = {halves[2 * i + 1], halves[2 * i]};
			mem[i] = {w[7:0], w[15:8], w[23:16], w[31:24]};
		end
	endtask

	initial begin
		string name;
		logic [31:0] r;
		int h;
		int ptr;
		int cycles;
		int burst_left;
		int jumps_left;
		int target_rec;
		logic stall_now;
		logic jump_now;
		// previous cycle was neither stalled nor a jump
		logic prev_active;
		// upper half of a straddling record already buffered
		logic half_done;
		addr_t fetch_pc;
		rst_n = 1'b0;
		stall_i = 1'b0;
		jump_i = 1'b0;
		jump_target_i = '0;
		fetch_data_i = '0;
		lfsr = 16'd46;
		build_stream();
		fetch_data_i = mem[0];
		repeat (10) @(posedge clk);
		#1;
		check_pc("fetch address after reset", RESET_PC, fetch_addr_o);
		check_pc("pc after reset", 32'd0, instr_pc_o);
		check_instr("instruction after reset", 32'd0, instr_o);
		check_flag("valid after reset", 1'b0, instr_valid_o);
		check_flag("compressed flag after reset", 1'b0, is_compress_o);
		rst_n = 1'b1;
		ptr = 0;
		cycles = 0;
		burst_left = 0;
		jumps_left = 6;
		target_rec = 0;
		prev_active = 1'b1;
		half_done = 1'b0;
		while (ptr < num_rec) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > MAX_CYCLES) begin
				report_failure("the instruction stream did not finish within the cycle limit");
			end
			// occasional stall bursts of one to four cycles
			if (burst_left == 0) begin
				r = take_bits(3);
				if (r == 32'd0) begin
					r = take_bits(2);
					burst_left = r + 1;
				end
			end
			stall_now = (burst_left > 0);
			if (stall_now) burst_left--;
			// jumps only once all forms were seen
			jump_now = 1'b0;
			if (!stall_now && jumps_left > 0 && ptr > 40 && ptr < num_rec - 40) begin
				r = take_bits(4);
				if (r == 32'd0) begin
					h = take_bits(8);
					while (start_rec[h] < 0) h = (h + 1) % MEM_HALVES;
					jump_now = 1'b1;
					jumps_left--;
					target_rec = start_rec[h];
					jump_target_i = h * 2;
				end
			end
			stall_i = stall_now;
			jump_i = jump_now;
			fetch_data_i = mem[fetch_addr_o[8:2]];
			@(negedge clk);
			// outputs here belong to the previous cycle
			name = $sformatf("record %0d at pc %08h", ptr, exp_pc[ptr]);
			if (!prev_active) begin
				// stall or jump leaves a bubble
				check_flag({name, " valid after bubble"}, 1'b0, instr_valid_o);
			end else if (!exp_comp[ptr] && exp_pc[ptr][1] && !half_done) begin
				// upper half only went into the buffer
				check_flag({name, " valid while buffering"}, 1'b0, instr_valid_o);
				half_done = 1'b1;
			end else begin
				check_flag({name, " valid"}, 1'b1, instr_valid_o);
				check_instr({name, " word"}, exp_instr[ptr], instr_o);
				check_pc({name, " pc"}, exp_pc[ptr], instr_pc_o);
				check_flag({name, " compressed flag"}, exp_comp[ptr], is_compress_o);
				ptr++;
				half_done = 1'b0;
			end
			// word holding the next halfword to consume
			if (ptr < num_rec) begin
				fetch_pc = exp_pc[ptr] + (half_done ? 32'd2 : 32'd0);
				check_pc($sformatf("fetch address in cycle %0d", cycles),
				         {fetch_pc[31:2], 2'b00}, fetch_addr_o);
			end
			prev_active = !stall_now && !jump_now;
			if (jump_now) begin
				ptr = target_rec;
				half_done = 1'b0;
			end
		end
		if (jumps_left < 6) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			report_failure("no jump was taken during the run");
		end
	end
endmodule

//--- tb/rvc_fetch_assertions.sv
`timescale 1ns/10ps

module rvc_fetch_assertions (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   stall_i,
	input logic                   jump_i,
	input logic                   emit,
	input logic                   advance,
	input rvc_pkg::align_state_e state_q
);
	import rvc_pkg::*;

	// jump cycle registers no output, so the next cycle shows nothing
	property no_emit_on_jump;
		@(posedge clk) disable iff (!rst_n)
		(jump_i && !stall_i) |-> !emit;
	endproperty

	// split state consumes the current word's low half only
	property no_advance_in_split;
		@(posedge clk) disable iff (!rst_n)
		(state_q == ALIGN_SPLIT) |-> !advance;
	endproperty

	// stall freezes the fsm
	property state_held_on_stall;
		@(posedge clk) disable iff (!rst_n)
		stall_i |=> $stable(state_q);
	endproperty

	assert property (no_emit_on_jump)
		else $error("emit raised in a jump cycle");
	assert property (no_advance_in_split)
		else $error("advance raised in ALIGN_SPLIT");
	assert property (state_held_on_stall)
		else $error("state changed under stall");
endmodule

bind align_ctrl rvc_fetch_assertions align_checks_inst (
	.clk     (clk),
	.rst_n   (rst_n),
	.stall_i (stall_i),
	.jump_i  (jump_i),
	.emit    (ctrl_if.emit),
	.advance (ctrl_if.advance),
	.state_q (state_q)
);

//--- hw/rvc_fetch_top.sv
`timescale 1ns/10ps

module rvc_fetch_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall_i,
	input  logic            jump_i,
	input  rvc_pkg::addr_t  jump_target_i,
	// byte-reversed cache word
	input  rvc_pkg::instr_t fetch_data_i,
	output rvc_pkg::addr_t  fetch_addr_o,
	output rvc_pkg::instr_t instr_o,
	output rvc_pkg::addr_t  instr_pc_o,
	output logic            instr_valid_o,
	output logic            is_compress_o
);
	import rvc_pkg::*;

	half_t  compressed;
	instr_t expanded;

	// steering bundle
	align_if align_bus ();

	align_ctrl align_ctrl_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall_i     (stall_i),
		.jump_i      (jump_i),
		.jump_half_i (jump_target_i[1]),
		.ctrl_if     (align_bus)
	);

	fetch_pc_counter fetch_pc_counter_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall_i       (stall_i),
		.jump_target_i (jump_target_i),
		.fetch_addr_o  (fetch_addr_o),
		.instr_pc_o    (instr_pc_o),
		.cnt_if        (align_bus)
	);

	instr_assembler instr_assembler_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall_i       (stall_i),
		.fetch_data_i  (fetch_data_i),
		.expanded_i    (expanded),
		.compressed_o  (compressed),
		.instr_o       (instr_o),
		.instr_valid_o (instr_valid_o),
		.is_compress_o (is_compress_o),
		.dp_if         (align_bus)
	);

	rvc_expander rvc_expander_inst (
		.compressed_i (compressed),
		.expanded_o   (expanded)
	);
endmodule

//--- fetch/instr_assembler.sv
`timescale 1ns/10ps

module instr_assembler (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall_i,
	input  rvc_pkg::instr_t fetch_data_i,
	input  rvc_pkg::instr_t expanded_i,
	output rvc_pkg::half_t  compressed_o,
	output rvc_pkg::instr_t instr_o,
	output logic            instr_valid_o,
	output logic            is_compress_o,
	align_if.datapath       dp_if
);
	import rvc_pkg::*;

	instr_t word;
	half_t  half_lo;
	half_t  half_hi;
	// upper half of a straddling instruction
	half_t  split_buf;
	instr_t instr_q;
	logic   valid_q;
	logic   compress_q;

	// cache delivers the word byte-reversed
	assign word    = {fetch_data_i[7:0], fetch_data_i[15:8],
	                  fetch_data_i[23:16], fetch_data_i[31:24]};
	assign half_lo = word[15:0];
	assign half_hi = word[31:16];

	assign dp_if.len_lo = half_lo[1:0];
	assign dp_if.len_hi = half_hi[1:0];

	// parcel handed to the expander
	assign compressed_o = dp_if.sel_high ? half_hi : half_lo;

	always_ff @(posedge clk) begin
		if (!stall_i && dp_if.load_buf) begin
			split_buf <= half_hi;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			instr_q    <= '0;
			valid_q    <= 1'b0;
			compress_q <= 1'b0;
		end else if (stall_i) begin
			// hold data, show a bubble
			valid_q <= 1'b0;
		end else begin
			valid_q <= dp_if.emit;
			if (dp_if.emit) begin
				if (dp_if.use_buf) begin
					instr_q    <= {half_lo, split_buf};
					compress_q <= 1'b0;
				end else if (dp_if.pc_step) begin
					instr_q    <= word;
					compress_q <= 1'b0;
				end else begin
					instr_q    <= expanded_i;
					compress_q <= 1'b1;
				end
			end
		end
	end

	assign instr_o       = instr_q;
	assign instr_valid_o = valid_q;
	assign is_compress_o = compress_q;
endmodule

//--- fetch/fetch_pc_counter.sv
`timescale 1ns/10ps

module fetch_pc_counter (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           stall_i,
	input  rvc_pkg::addr_t jump_target_i,
	output rvc_pkg::addr_t fetch_addr_o,
	output rvc_pkg::addr_t instr_pc_o,
	align_if.counter       cnt_if
);
	import rvc_pkg::*;

	addr_t fetch_addr_q;
	// start address of the next instruction
	addr_t pc_q;
	addr_t instr_pc_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_addr_q <= RESET_PC;
			pc_q         <= RESET_PC;
			instr_pc_q   <= '0;
		end else if (!stall_i) begin
			if (cnt_if.jump_load) begin
				// word address drops the byte offset
				fetch_addr_q <= {jump_target_i[31:2], 2'b00};
				pc_q         <= jump_target_i;
			end else begin
				if (cnt_if.advance) begin
					fetch_addr_q <= fetch_addr_q + 32'd4;
				end
				if (cnt_if.emit) begin
					instr_pc_q <= pc_q;
					pc_q       <= pc_q + (cnt_if.pc_step ? 32'd4 : 32'd2);
				end
			end
		end
	end

	assign fetch_addr_o = fetch_addr_q;
	assign instr_pc_o   = instr_pc_q;
endmodule

//--- fetch/align_ctrl.sv
`timescale 1ns/10ps

module align_ctrl (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  stall_i,
	input  logic  jump_i,
	// bit 1 of the jump target
	input  logic  jump_half_i,
	align_if.ctrl ctrl_if
);
	import rvc_pkg::*;

	align_state_e state_q;
	align_state_e state_d;
	logic lo_is_wide;
	logic hi_is_wide;

	// a half ending in 11 opens a 32-bit instruction
	assign lo_is_wide = (ctrl_if.len_lo == 2'b11);
	assign hi_is_wide = (ctrl_if.len_hi == 2'b11);

	always_comb begin
		state_d           = state_q;
		ctrl_if.sel_high  = 1'b0;
		ctrl_if.load_buf  = 1'b0;
		ctrl_if.use_buf   = 1'b0;
		ctrl_if.emit      = 1'b0;
		ctrl_if.advance   = 1'b0;
		ctrl_if.pc_step   = 1'b0;
		ctrl_if.jump_load = 1'b0;
		if (stall_i) begin
			// everything frozen, no strobes
			state_d = state_q;
		end else if (jump_i) begin
			// restart at the target, nothing emitted
			ctrl_if.jump_load = 1'b1;
			state_d = jump_half_i ? ALIGN_HIGH : ALIGN_LOW;
		end else begin
			case (state_q)
				ALIGN_LOW: begin
					ctrl_if.emit = 1'b1;
					if (lo_is_wide) begin
						// whole word is one instruction
						ctrl_if.pc_step = 1'b1;
						ctrl_if.advance = 1'b1;
					end else begin
						// low parcel compressed, upper half next
						state_d = ALIGN_HIGH;
					end
				end
				ALIGN_HIGH: begin
					ctrl_if.sel_high = 1'b1;
					ctrl_if.advance  = 1'b1;
					if (hi_is_wide) begin
						// first half of a straddling instruction
						ctrl_if.load_buf = 1'b1;
						state_d = ALIGN_SPLIT;
					end else begin
						ctrl_if.emit = 1'b1;
						state_d = ALIGN_LOW;
					end
				end
				ALIGN_SPLIT: begin
					// low half completes the buffered instruction
					ctrl_if.use_buf = 1'b1;
					ctrl_if.emit    = 1'b1;
					ctrl_if.pc_step = 1'b1;
					state_d = ALIGN_HIGH;
				end
				default: begin
					state_d = ALIGN_LOW;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ALIGN_LOW;
		end else begin
			state_q <= state_d;
		end
	end
endmodule

//--- expander/rvc_expander.sv
`timescale 1ns/10ps

module rvc_expander (
	input  rvc_pkg::half_t  compressed_i,
	output rvc_pkg::instr_t expanded_o
);
	import rvc_pkg::*;

	half_t      c;
	c_op_e      op;
	logic [4:0] rd_full;
	logic [4:0] rs2_full;
	logic [4:0] rd_p;
	logic [4:0] rs1_p;
	logic [5:0] imm6;
	logic [11:0] imm12;
	logic [11:0] lw_off;
	logic [11:0] j_off;
	logic [8:0] b_off;

	assign c = compressed_i;

	// full register fields
	assign rd_full  = c[11:7];
	assign rs2_full = c[6:2];
	// primed registers map to x8..x15
	assign rd_p  = {2'b01, c[4:2]};
	assign rs1_p = {2'b01, c[9:7]};

	// ci-format immediate, sign extended
	assign imm6  = {c[12], c[6:2]};
	assign imm12 = {{6{c[12]}}, imm6};

	// word offset of lw and sw
	assign lw_off = {5'b0, c[5], c[12:10], c[6], 2'b00};

	// scrambled jump offset
	assign j_off = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};

	// branch offset
	assign b_off = {c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};

	// quadrant and funct3 pick the form
	always_comb begin
		op = C_ILLEGAL;
		case ({c[1:0], c[15:13]})
			5'b00_010: op = C_LW;
			5'b00_110: op = C_SW;
			5'b01_000: op = C_ADDI;
			5'b01_010: op = C_LI;
			5'b01_011: begin
				// rd x2 is addi16sp, zero imm reserved
				if (rd_full != 5'd2 && imm6 != 6'd0) begin
					op = C_LUI;
				end
			end
			5'b01_101: op = C_J;
			5'b01_110: op = C_BEQZ;
			5'b01_111: op = C_BNEZ;
			5'b10_000: begin
				// shamt bit 5 reserved on rv32
				if (!c[12]) begin
					op = C_SLLI;
				end
			end
			5'b10_100: begin
				if (!c[12]) begin
					if (rs2_full != 5'd0) begin
						op = C_MV;
					end else if (rd_full != 5'd0) begin
						op = C_JR;
					end
				end else if (rs2_full != 5'd0) begin
					op = C_ADD;
				end
				// jalr and ebreak stay illegal
			end
			default: op = C_ILLEGAL;
		endcase
	end

	always_comb begin
		expanded_o = ILLEGAL_INSTR;
		case (op)
			C_LW: begin
				expanded_o = {lw_off, rs1_p, 3'b010, rd_p, OPC_LOAD};
			end
			C_SW: begin
				// rs2 sits where rd' sits in the loads
				expanded_o = {lw_off[11:5], rd_p, rs1_p, 3'b010, lw_off[4:0], OPC_STORE};
			end
			C_ADDI: begin
				expanded_o = {imm12, rd_full, 3'b000, rd_full, OPC_OP_IMM};
			end
			C_LI: begin
				expanded_o = {imm12, 5'd0, 3'b000, rd_full, OPC_OP_IMM};
			end
			C_LUI: begin
				expanded_o = {{14{c[12]}}, imm6, rd_full, OPC_LUI};
			end
			C_SLLI: begin
				expanded_o = {7'b0, c[6:2], rd_full, 3'b001, rd_full, OPC_OP_IMM};
			end
			C_MV: begin
				expanded_o = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, OPC_OP};
			end
			C_ADD: begin
				expanded_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, OPC_OP};
			end
			C_J: begin
				// jal x0
				expanded_o = {c[12], j_off[10:1], c[12], {8{c[12]}}, 5'd0, OPC_JAL};
			end
			C_JR: begin
				expanded_o = {12'd0, rd_full, 3'b000, 5'd0, OPC_JALR};
			end
			C_BEQZ: begin
				expanded_o = {c[12], {2{c[12]}}, b_off[8:5], 5'd0, rs1_p, 3'b000,
				              b_off[4:1], c[12], OPC_BRANCH};
			end
			C_BNEZ: begin
				expanded_o = {c[12], {2{c[12]}}, b_off[8:5], 5'd0, rs1_p, 3'b001,
				              b_off[4:1], c[12], OPC_BRANCH};
			end
			default: begin
				expanded_o = ILLEGAL_INSTR;
			end
		endcase
	end
endmodule

//--- common/align_if.sv
`timescale 1ns/10ps

interface align_if;
	// steering from the controller
	logic sel_high;
	logic load_buf;
	logic use_buf;
	logic emit;
	logic advance;
	// high means a 4-byte instruction
	logic pc_step;
	logic jump_load;
	// length bits of both halves after the swap
	logic [1:0] len_lo;
	logic [1:0] len_hi;

	modport ctrl (
		output sel_high, load_buf, use_buf, emit, advance, pc_step, jump_load,
		input  len_lo, len_hi
	);

	modport datapath (
		input  sel_high, load_buf, use_buf, emit, pc_step,
		output len_lo, len_hi
	);

	modport counter (
		input advance, pc_step, emit, jump_load
	);
endinterface

//--- common/rvc_pkg.sv
package rvc_pkg;

	// one 32-bit instruction word
	typedef logic [31:0] instr_t;

	// one 16-bit parcel
	typedef logic [15:0] half_t;

	// byte address
	typedef logic [31:0] addr_t;

	// where the next instruction starts
	typedef enum logic [1:0] {
		ALIGN_LOW   = 2'd0,
		ALIGN_HIGH  = 2'd1,
		ALIGN_SPLIT = 2'd2
	} align_state_e;

	// supported compressed forms
	typedef enum logic [3:0] {
		C_LW, C_SW,
		C_ADDI, C_LI, C_LUI, C_SLLI,
		C_MV, C_ADD,
		C_J, C_JR,
		C_BEQZ, C_BNEZ,
		C_ILLEGAL
	} c_op_e;

	// base opcodes the expander produces
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011
	} rv_opc_e;

	localparam addr_t RESET_PC = 32'h0000_0000;
	localparam instr_t ILLEGAL_INSTR = 32'h0000_0000;

endpackage
